/* Bender.yml */
package:
  name: rv_exec_core

sources:
  - rv_exec_pkg.sv
  - instr_decoder.sv
  - reg_file.sv
  - id_ex_regs.sv
  - ex_stage.sv
  - wb_stage.sv
  - rv_exec_core.sv
  - target: test
    files:
      - tb_rv_exec_core.sv

/* ex_stage.sv */
module ex_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1_i, rs2_i, rd_i,
	input  logic [rv_exec_pkg::XLEN-1:0] imm_i, pc_add_imm_i, pc_add_4_i,
	input  logic [rv_exec_pkg::XLEN-1:0] rs1_data_i, rs2_data_i,
	input  rv_exec_pkg::alu_op_e alu_ctl_i,
	input  logic alu_src_pc_i, alu_src_imm_i, reg_write_i,
	input  logic branch_i, jal_i, jalr_i,
	input  logic [2:0] funct3_i,
	input  logic fwd_we_i,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] fwd_rd_i,
	input  logic [rv_exec_pkg::XLEN-1:0] fwd_data_i,
	output logic [rv_exec_pkg::XLEN-1:0] result_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_o,
	output logic reg_write_o,
	output logic redirect_o,
	output logic [rv_exec_pkg::XLEN-1:0] redirect_pc_o
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] rs1_val, rs2_val, pc, op_a, op_b, alu_out;
	logic taken;

	// fwd_we_i already excludes x0.
	assign rs1_val = (fwd_we_i && fwd_rd_i == rs1_i) ? fwd_data_i : rs1_data_i;
	assign rs2_val = (fwd_we_i && fwd_rd_i == rs2_i) ? fwd_data_i : rs2_data_i;

	assign pc = pc_add_4_i - 32'd4;
	assign op_a = alu_src_pc_i ? pc : rs1_val;
	assign op_b = alu_src_imm_i ? imm_i : rs2_val;

	always_comb
	begin
		case (alu_ctl_i)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_SLL: alu_out = op_a << op_b[4:0];
			ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_out = {31'b0, op_a < op_b};
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SRL: alu_out = op_a >> op_b[4:0];
			ALU_SRA: alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
			ALU_OR: alu_out = op_a | op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	always_comb
	begin
		case (funct3_i)
			F3_BEQ: taken = (rs1_val == rs2_val);
			F3_BNE: taken = (rs1_val != rs2_val);
			F3_BLT: taken = $signed(rs1_val) < $signed(rs2_val);
			F3_BGE: taken = $signed(rs1_val) >= $signed(rs2_val);
			F3_BLTU: taken = rs1_val < rs2_val;
			F3_BGEU: taken = rs1_val >= rs2_val;
			default: taken = 1'b0;
		endcase
	end

	assign result_o = (jal_i || jalr_i) ? pc_add_4_i : alu_out;	// Link value.
	assign rd_o = rd_i;
	assign reg_write_o = reg_write_i;

	assign redirect_o = (branch_i && taken) || jal_i || jalr_i;
	assign redirect_pc_o = jalr_i ? {alu_out[XLEN-1:1], 1'b0} : pc_add_imm_i;

	a_one_ctl: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({branch_i, jal_i, jalr_i}));

endmodule

/* id_ex_regs.sv */
module id_ex_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	input  logic stall_i,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1_i, rs2_i, rd_i,
	input  logic [rv_exec_pkg::XLEN-1:0] imm_i, pc_add_imm_i, pc_add_4_i,
	input  logic [rv_exec_pkg::XLEN-1:0] rs1_data_i, rs2_data_i,
	input  rv_exec_pkg::alu_op_e alu_ctl_i,
	input  logic alu_src_pc_i, alu_src_imm_i, reg_write_i,
	input  logic branch_i, jal_i, jalr_i, ecall_i,
	input  logic [2:0] funct3_i,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1_o, rs2_o, rd_o,
	output logic [rv_exec_pkg::XLEN-1:0] imm_o, pc_add_imm_o, pc_add_4_o,
	output logic [rv_exec_pkg::XLEN-1:0] rs1_data_o, rs2_data_o,
	output rv_exec_pkg::alu_op_e alu_ctl_o,
	output logic alu_src_pc_o, alu_src_imm_o, reg_write_o,
	output logic branch_o, jal_o, jalr_o,
	output logic [2:0] funct3_o,
	output logic halted_o
);
	import rv_exec_pkg::*;

	logic bubble;

	assign bubble = flush_i || stall_i;

	// Sticky halt that only reset clears.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			halted_o <= 1'b0;
		else if (!bubble && ecall_i)
			halted_o <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || bubble)
		begin
			alu_ctl_o <= ALU_ADD;
			alu_src_pc_o <= 1'b0;
			alu_src_imm_o <= 1'b0;
			reg_write_o <= 1'b0;
			branch_o <= 1'b0;
			jal_o <= 1'b0;
			jalr_o <= 1'b0;
		end
		else
		begin
			alu_ctl_o <= alu_ctl_i;
			alu_src_pc_o <= alu_src_pc_i;
			alu_src_imm_o <= alu_src_imm_i;
			reg_write_o <= reg_write_i;
			branch_o <= branch_i;
			jal_o <= jal_i;
			jalr_o <= jalr_i;
		end
	end

	always_ff @(posedge clk)
	begin
		rs1_o <= rs1_i;
		rs2_o <= rs2_i;
		rd_o <= rd_i;
		imm_o <= imm_i;
		pc_add_imm_o <= pc_add_imm_i;
		pc_add_4_o <= pc_add_4_i;
		rs1_data_o <= rs1_data_i;
		rs2_data_o <= rs2_data_i;
		funct3_o <= funct3_i;
	end

	a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |=> !(reg_write_o || branch_o || jal_o || jalr_o));

endmodule

/* instr_decoder.sv */
module instr_decoder (
	input  rv_exec_pkg::instr_word_u instr_i,
	input  logic [rv_exec_pkg::XLEN-1:0] pc_i,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rs2_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_o,
	output logic [rv_exec_pkg::XLEN-1:0] imm_o,
	output logic [rv_exec_pkg::XLEN-1:0] pc_add_imm_o,
	output logic [rv_exec_pkg::XLEN-1:0] pc_add_4_o,
	output rv_exec_pkg::alu_op_e alu_ctl_o,
	output logic alu_src_pc_o,
	output logic alu_src_imm_o,
	output logic reg_write_o,
	output logic branch_o,
	output logic jal_o,
	output logic jalr_o,
	output logic ecall_o,
	output logic [2:0] funct3_o
);
	import rv_exec_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;
	alu_op_e alu_op;

	assign opcode = instr_i.r_view.opcode;
	assign funct3 = instr_i.r_view.funct3;
	assign alt = (instr_i.r_view.funct7 == F7_ALT);

	assign rs1_o = instr_i.r_view.rs1;
	assign rs2_o = instr_i.r_view.rs2;
	assign rd_o = instr_i.r_view.rd;
	assign funct3_o = funct3;

	always_comb
	begin
		case (funct3)
			F3_ADD: alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;	// No SUBI.
			F3_SLL: alu_op = ALU_SLL;
			F3_SLT: alu_op = ALU_SLT;
			F3_SLTU: alu_op = ALU_SLTU;
			F3_XOR: alu_op = ALU_XOR;
			F3_SR: alu_op = alt ? ALU_SRA : ALU_SRL;
			F3_OR: alu_op = ALU_OR;
			F3_AND: alu_op = ALU_AND;
			default: alu_op = ALU_ADD;
		endcase
	end

	always_comb
	begin
		imm_o = '0;
		alu_ctl_o = ALU_ADD;
		alu_src_pc_o = 1'b0;
		alu_src_imm_o = 1'b0;
		reg_write_o = 1'b0;
		branch_o = 1'b0;
		jal_o = 1'b0;
		jalr_o = 1'b0;
		ecall_o = 1'b0;
		case (opcode)
			OPC_OP:
			begin
				alu_ctl_o = alu_op;
				reg_write_o = 1'b1;
			end
			OPC_OP_IMM:
			begin
				imm_o = {{20{instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};
				alu_ctl_o = alu_op;
				alu_src_imm_o = 1'b1;
				reg_write_o = 1'b1;
			end
			OPC_LUI, OPC_AUIPC:
			begin
				imm_o = {instr_i.i_view.imm12, instr_i.i_view.rs1, instr_i.i_view.funct3, 12'b0};
				alu_ctl_o = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
				alu_src_pc_o = (opcode == OPC_AUIPC);
				alu_src_imm_o = 1'b1;
				reg_write_o = 1'b1;
			end
			OPC_BRANCH:
			begin
				imm_o = {{20{instr_i.b_view.imm12}}, instr_i.b_view.imm11,
					instr_i.b_view.imm10_5, instr_i.b_view.imm4_1, 1'b0};
				branch_o = 1'b1;
			end
			OPC_JAL:
			begin
				imm_o = {{12{instr_i.j_view.imm20}}, instr_i.j_view.imm19_12,
					instr_i.j_view.imm11, instr_i.j_view.imm10_1, 1'b0};
				jal_o = 1'b1;
				reg_write_o = 1'b1;
			end
			OPC_JALR:
			begin
				imm_o = {{20{instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};
				alu_src_imm_o = 1'b1;	// ALU forms rs1 + imm as target.
				jalr_o = 1'b1;
				reg_write_o = 1'b1;
			end
			OPC_SYSTEM: ecall_o = (instr_i.i_view.imm12 == 12'h000) && (funct3 == 3'b000);
			default: ;
		endcase
	end

	assign pc_add_imm_o = pc_i + imm_o;
	assign pc_add_4_o = pc_i + 32'd4;

endmodule

/* reg_file.sv */
module reg_file (
	input  logic clk,
	input  logic rst_n,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] raddr1_i,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] raddr2_i,
	output logic [rv_exec_pkg::XLEN-1:0] rdata1_o,
	output logic [rv_exec_pkg::XLEN-1:0] rdata2_o,
	input  logic we_i,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] waddr_i,
	input  logic [rv_exec_pkg::XLEN-1:0] wdata_i
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] regs [1:(2**REG_ADDR_W)-1];	// No storage for x0.
	logic wr_en;

	assign wr_en = we_i && (waddr_i != '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[waddr_i] <= wdata_i;
	end

	// Write-through so decode sees the value retiring this cycle.
	assign rdata1_o = (raddr1_i == '0) ? '0 :
		(wr_en && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 :
		(wr_en && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		we_i |-> (waddr_i != '0));

endmodule

/* rv_exec_core.f */
rv_exec_pkg.sv
instr_decoder.sv
reg_file.sv
id_ex_regs.sv
ex_stage.sv
wb_stage.sv
rv_exec_core.sv
tb_rv_exec_core.sv

/* rv_exec_core.sv */
module rv_exec_core (
	input  logic clk,
	input  logic rst_n,
	input  logic instr_valid_i,
	input  rv_exec_pkg::instr_word_u instr_i,
	input  logic [rv_exec_pkg::XLEN-1:0] pc_i,
	output logic redirect_o,
	output logic [rv_exec_pkg::XLEN-1:0] redirect_pc_o,
	output logic wb_valid_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [rv_exec_pkg::XLEN-1:0] wb_data_o,
	output logic halted_o
);
	import rv_exec_pkg::*;

	logic [REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd, ex_rs1, ex_rs2, ex_rd, res_rd;
	logic [XLEN-1:0] dec_imm, dec_pc_imm, dec_pc_4, rf_rdata1, rf_rdata2;
	logic [XLEN-1:0] ex_imm, ex_pc_imm, ex_pc_4, ex_rs1_data, ex_rs2_data, ex_result;
	alu_op_e dec_alu_ctl, ex_alu_ctl;
	logic dec_src_pc, dec_src_imm, dec_reg_write, dec_branch, dec_jal, dec_jalr, dec_ecall;
	logic ex_src_pc, ex_src_imm, ex_reg_write, ex_branch, ex_jal, ex_jalr, res_reg_write;
	logic [2:0] dec_funct3, ex_funct3;
	logic stall;

	assign stall = !instr_valid_i || halted_o;	// Nothing is accepted after ECALL.

	instr_decoder instr_decoder_inst (
		.instr_i, .pc_i,
		.rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
		.imm_o(dec_imm), .pc_add_imm_o(dec_pc_imm), .pc_add_4_o(dec_pc_4),
		.alu_ctl_o(dec_alu_ctl), .alu_src_pc_o(dec_src_pc), .alu_src_imm_o(dec_src_imm),
		.reg_write_o(dec_reg_write), .branch_o(dec_branch), .jal_o(dec_jal),
		.jalr_o(dec_jalr), .ecall_o(dec_ecall), .funct3_o(dec_funct3)
	);

	reg_file reg_file_inst (
		.clk, .rst_n,
		.raddr1_i(dec_rs1), .raddr2_i(dec_rs2),
		.rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2),
		.we_i(wb_valid_o), .waddr_i(wb_rd_o), .wdata_i(wb_data_o)
	);

	id_ex_regs id_ex_regs_inst (
		.clk, .rst_n, .flush_i(redirect_o), .stall_i(stall),
		.rs1_i(dec_rs1), .rs2_i(dec_rs2), .rd_i(dec_rd),
		.imm_i(dec_imm), .pc_add_imm_i(dec_pc_imm), .pc_add_4_i(dec_pc_4),
		.rs1_data_i(rf_rdata1), .rs2_data_i(rf_rdata2),
		.alu_ctl_i(dec_alu_ctl), .alu_src_pc_i(dec_src_pc), .alu_src_imm_i(dec_src_imm),
		.reg_write_i(dec_reg_write), .branch_i(dec_branch), .jal_i(dec_jal),
		.jalr_i(dec_jalr), .ecall_i(dec_ecall), .funct3_i(dec_funct3),
		.rs1_o(ex_rs1), .rs2_o(ex_rs2), .rd_o(ex_rd),
		.imm_o(ex_imm), .pc_add_imm_o(ex_pc_imm), .pc_add_4_o(ex_pc_4),
		.rs1_data_o(ex_rs1_data), .rs2_data_o(ex_rs2_data),
		.alu_ctl_o(ex_alu_ctl), .alu_src_pc_o(ex_src_pc), .alu_src_imm_o(ex_src_imm),
		.reg_write_o(ex_reg_write), .branch_o(ex_branch), .jal_o(ex_jal),
		.jalr_o(ex_jalr), .funct3_o(ex_funct3), .halted_o
	);

	ex_stage ex_stage_inst (
		.clk, .rst_n,
		.rs1_i(ex_rs1), .rs2_i(ex_rs2), .rd_i(ex_rd),
		.imm_i(ex_imm), .pc_add_imm_i(ex_pc_imm), .pc_add_4_i(ex_pc_4),
		.rs1_data_i(ex_rs1_data), .rs2_data_i(ex_rs2_data),
		.alu_ctl_i(ex_alu_ctl), .alu_src_pc_i(ex_src_pc), .alu_src_imm_i(ex_src_imm),
		.reg_write_i(ex_reg_write), .branch_i(ex_branch), .jal_i(ex_jal),
		.jalr_i(ex_jalr), .funct3_i(ex_funct3),
		.fwd_we_i(wb_valid_o), .fwd_rd_i(wb_rd_o), .fwd_data_i(wb_data_o),
		.result_o(ex_result), .rd_o(res_rd), .reg_write_o(res_reg_write),
		.redirect_o, .redirect_pc_o
	);

	wb_stage wb_stage_inst (
		.clk, .rst_n,
		.result_i(ex_result), .rd_i(res_rd), .reg_write_i(res_reg_write),
		.wb_valid_o, .wb_rd_o, .wb_data_o
	);

endmodule

/* rv_exec_pkg.sv */
package rv_exec_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// Major opcodes.
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [6:0] F7_ALT = 7'b0100000;	// SUB and SRA(I).

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,	// Bubble is add x0, x0, x0.
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_view;
		struct packed {
			logic imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic imm11;
			logic [6:0] opcode;
		} b_view;
		struct packed {
			logic imm20;
			logic [9:0] imm10_1;
			logic imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_view;
	} instr_word_u;

endpackage

/* tb_rv_exec_core.sv */
module tb_rv_exec_core;
	import rv_exec_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int TIMEOUT = 4 * PROG_LEN + 100;
	localparam logic [31:0] ECALL_WORD = 32'h00000073;

	typedef enum int {K_R, K_I, K_LUI, K_AUIPC, K_BR, K_JAL, K_BASE_HI, K_BASE_LO, K_JALR,
		K_ECALL} kind_e;

	logic clk;
	logic rst_n;
	logic instr_valid_i;
	instr_word_u instr_i;
	logic [XLEN-1:0] pc_i;
	logic redirect_o;
	logic [XLEN-1:0] redirect_pc_o;
	logic wb_valid_o;
	logic [REG_ADDR_W-1:0] wb_rd_o;
	logic [XLEN-1:0] wb_data_o;
	logic halted_o;

	instr_word_u prog [0:PROG_LEN-1];
	int kind [0:PROG_LEN-1];
	logic valid_pat [0:1023];
	logic [XLEN-1:0] ref_regs [0:31];
	logic [36:0] exp_wr_q [$];	// {rd, data}.
	logic [XLEN-1:0] exp_redir_q [$];
	int cycles = 0;

	rv_exec_core rv_exec_core_inst (.*);

	always #50 clk = ~clk;

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	function automatic instr_word_u prog_word(input logic [XLEN-1:0] pc);
		if (pc[XLEN-1:2] < PROG_LEN)
			return prog[pc[XLEN-1:2]];
		return ECALL_WORD;	// Past the end only while halted.
	endfunction

	function automatic int pick_target(input int i);
		int t;
		t = i + $urandom_range(1, 6);
		if (t > PROG_LEN - 1)
			t = PROG_LEN - 1;
		while (kind[t] == K_BASE_LO || kind[t] == K_JALR)
			t++;	// Never land inside a JALR base sequence.
		return t;
	endfunction

	function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// One RV32I step on ref_regs.
	function automatic void iss_step(input instr_word_u w, input logic [XLEN-1:0] pc,
		output logic wr, output logic [REG_ADDR_W-1:0] rd, output logic [XLEN-1:0] data,
		output logic jump, output logic [XLEN-1:0] next_pc);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm_i;
		logic [XLEN-1:0] imm_b;
		logic [XLEN-1:0] imm_j;
		a = ref_regs[w.r_view.rs1];
		b = ref_regs[w.r_view.rs2];
		imm_i = {{20{w.i_view.imm12[11]}}, w.i_view.imm12};
		imm_b = {{20{w.b_view.imm12}}, w.b_view.imm11, w.b_view.imm10_5, w.b_view.imm4_1, 1'b0};
		imm_j = {{12{w.j_view.imm20}}, w.j_view.imm19_12, w.j_view.imm11, w.j_view.imm10_1, 1'b0};
		rd = w.r_view.rd;
		wr = 1'b1;
		data = '0;
		jump = 1'b0;
		next_pc = pc + 4;
		case (w.r_view.opcode)
			OPC_OP: data = alu_ref(w.r_view.funct3, w.r_view.funct7[5], a, b);
			OPC_OP_IMM: data = alu_ref(w.i_view.funct3,
				w.i_view.funct3 == 3'b101 && w.i_view.imm12[10], a, imm_i);
			OPC_LUI: data = {w[31:12], 12'b0};
			OPC_AUIPC: data = pc + {w[31:12], 12'b0};
			OPC_BRANCH:
			begin
				wr = 1'b0;
				case (w.b_view.funct3)
					3'b000: jump = (a == b);
					3'b001: jump = (a != b);
					3'b100: jump = ($signed(a) < $signed(b));
					3'b101: jump = ($signed(a) >= $signed(b));
					3'b110: jump = (a < b);
					default: jump = (a >= b);
				endcase
				if (jump)
					next_pc = pc + imm_b;
			end
			OPC_JAL:
			begin
				data = pc + 4;
				jump = 1'b1;
				next_pc = pc + imm_j;
			end
			OPC_JALR:
			begin
				data = pc + 4;
				jump = 1'b1;
				next_pc = (a + imm_i) & ~32'd1;
			end
			default: wr = 1'b0;
		endcase
		wr = wr && (rd != '0);
		if (wr)
			ref_regs[rd] = data;
	endfunction

	task automatic build_program();
		int i;
		int r;
		logic [2:0] f3;
		logic [11:0] lo;
		logic [12:0] boff;
		logic [20:0] joff;
		instr_word_u w;
		i = 0;
		while (i < PROG_LEN - 1)
		begin
			if (i + 3 < PROG_LEN && $urandom_range(0, 15) == 0)
			begin
				kind[i] = K_BASE_HI;
				kind[i + 1] = K_BASE_LO;
				kind[i + 2] = K_JALR;
				i += 3;
			end
			else
			begin
				r = $urandom_range(0, 11);
				kind[i] = (r < 4) ? K_R : (r < 7) ? K_I : (r == 7) ? K_LUI :
					(r == 8) ? K_AUIPC : (r < 11) ? K_BR : K_JAL;
				i++;
			end
		end
		kind[PROG_LEN - 1] = K_ECALL;
		for (i = 0; i < PROG_LEN; i++)
		begin
			w = '0;
			w.r_view.rd = $urandom_range(0, 7);	// Small register set for dense dependencies.
			w.r_view.rs1 = $urandom_range(0, 7);
			w.r_view.rs2 = $urandom_range(0, 7);
			f3 = $urandom_range(0, 7);
			case (kind[i])
				K_R:
				begin
					w.r_view.opcode = OPC_OP;
					w.r_view.funct3 = f3;
					if ((f3 == F3_ADD || f3 == F3_SR) && $urandom_range(0, 1))
						w.r_view.funct7 = F7_ALT;
				end
				K_I:
				begin
					w.i_view.opcode = OPC_OP_IMM;
					w.i_view.funct3 = f3;
					w.i_view.imm12 = $urandom;
					if (f3 == F3_SLL || f3 == F3_SR)
						w.i_view.imm12[11:5] = (f3 == F3_SR && $urandom_range(0, 1)) ? F7_ALT : 7'b0;
				end
				K_LUI, K_AUIPC:
				begin
					w[31:12] = $urandom;
					w.r_view.opcode = (kind[i] == K_LUI) ? OPC_LUI : OPC_AUIPC;
				end
				K_BR:
				begin
					boff = (pick_target(i) - i) * 4;
					r = $urandom_range(0, 5);
					w.b_view.funct3 = (r < 2) ? r : r + 2;	// Skips the two unused codes.
					w.b_view.imm12 = boff[12];
					w.b_view.imm11 = boff[11];
					w.b_view.imm10_5 = boff[10:5];
					w.b_view.imm4_1 = boff[4:1];
					w.b_view.opcode = OPC_BRANCH;
				end
				K_JAL:
				begin
					joff = (pick_target(i) - i) * 4;
					w.j_view.imm20 = joff[20];
					w.j_view.imm19_12 = joff[19:12];
					w.j_view.imm11 = joff[11];
					w.j_view.imm10_1 = joff[10:1];
					w.j_view.opcode = OPC_JAL;
				end
				K_BASE_HI: w = {20'b0, 5'd31, OPC_LUI};	// x31 holds JALR bases only.
				K_BASE_LO:
				begin
					lo = pick_target(i + 1) * 4 - 2;
					w = {lo, 5'd31, 3'b000, 5'd31, OPC_OP_IMM};
				end
				K_JALR: w = {12'd3, 5'd31, 3'b000, w.r_view.rd, OPC_JALR};	// Odd sum.
				default: w = ECALL_WORD;
			endcase
			prog[i] = w;
		end
		for (i = 0; i < 1024; i++)
			valid_pat[i] = ($urandom_range(0, 7) != 0);
	endtask

	task automatic run_reference();
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] next_pc;
		logic [XLEN-1:0] data;
		logic [REG_ADDR_W-1:0] rd;
		logic wr;
		logic jump;
		foreach (ref_regs[k])
			ref_regs[k] = '0;
		pc = '0;
		while (prog_word(pc) != ECALL_WORD)
		begin
			iss_step(prog_word(pc), pc, wr, rd, data, jump, next_pc);
			if (wr)
				exp_wr_q.push_back({rd, data});
			if (jump)
				exp_redir_q.push_back(next_pc);
			pc = next_pc;
		end
	endtask

	always @(posedge clk)
	begin : fetch
		logic [XLEN-1:0] next_pc;
		if (!rst_n)
			next_pc = '0;
		else if (redirect_o)
			next_pc = redirect_pc_o;
		else if (instr_valid_i)
			next_pc = pc_i + 4;
		else
			next_pc = pc_i;	// Stalled word is presented again.
		pc_i <= next_pc;
		instr_i <= prog_word(next_pc);
		instr_valid_i <= rst_n && valid_pat[cycles % 1024];
	end

	always @(negedge clk)
	begin : compare
		logic [36:0] exp_wr;
		logic [XLEN-1:0] exp_pc;
		if (rst_n && wb_valid_o)
		begin
			assert (exp_wr_q.size() > 0)
			else report_fail("A register write retired after the program reached ECALL");
			exp_wr = exp_wr_q.pop_front();
			assert (wb_rd_o == exp_wr[36:32] && wb_data_o == exp_wr[31:0])
			else report_fail($sformatf("MISMATCH t=%0t: wrote x%0d = %h, expected x%0d = %h",
				$time, wb_rd_o, wb_data_o, exp_wr[36:32], exp_wr[31:0]));
		end
		if (rst_n && redirect_o)
		begin
			assert (exp_redir_q.size() > 0)
			else report_fail("The core redirected although the program takes no more jumps");
			exp_pc = exp_redir_q.pop_front();
			assert (redirect_pc_o == exp_pc)
			else report_fail($sformatf("MISMATCH t=%0t: redirect to %h, expected %h",
				$time, redirect_pc_o, exp_pc));
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
			report_fail("Timeout: the core did not halt within the cycle limit");
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		pc_i = '0;
		void'($urandom(38));
		build_program();
		run_reference();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!redirect_o && !wb_valid_o && !halted_o)
		else report_fail("Redirect, writeback or halt was not low after reset");
		wait (halted_o);
		repeat (8) @(negedge clk);	// Room for the last writes ahead of ECALL.
		if (halted_o && exp_wr_q.size() == 0 && exp_redir_q.size() == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			report_fail("Halt dropped or expected writes or redirects never appeared");
	end

endmodule

/* wb_stage.sv */
module wb_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic [rv_exec_pkg::XLEN-1:0] result_i,
	input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic reg_write_i,
	output logic wb_valid_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [rv_exec_pkg::XLEN-1:0] wb_data_o
);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= reg_write_i && (rd_i != '0);	// x0 writes never retire.
	end

	always_ff @(posedge clk)
	begin
		wb_rd_o <= rd_i;
		wb_data_o <= result_i;
	end

endmodule
